//--- all.f
spiPkg.sv
memPkg.sv
spiIfs.sv
inputConditioner.sv
shiftRegister.sv
frameController.sv
dataMemory.sv
spiMemory.sv
tbClock.sv
spiMemoryTb.sv

//--- dataMemory.sv
module dataMemory import memPkg::*; (
    input  logic   clk,
    input  logic   reset,
    memPort.memory mem
);

    logic [addrWidth-1:0] addrReg;
    logic [dataWidth-1:0] memArray [memDepth];

    // command byte is {address, r/w}
    always_ff @(posedge clk) begin
        if (reset) begin
            addrReg <= '0;
        end else if (mem.addrLoad) begin
            addrReg <= mem.shiftData[dataWidth-1:1];
        end
    end

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (mem.writeEnable) begin
            memArray[addrReg] <= mem.shiftData;
        end
        mem.readData <= memArray[addrReg];      // one clk behind the address
    end

endmodule

//--- frameController.sv
module frameController import spiPkg::*; (
    input  logic       clk,
    input  logic       reset,
    condBus.sink       cond,
    memPort.controller mem,
    output logic       shiftLoad,
    output logic       misoEnable
);

    frameState             state;
    frameState             nextState;
    logic [countWidth-1:0] bitCount;
    logic                  counting;
    logic                  cmdDone;
    logic                  dataDone;
    logic                  readFrame;

    assign counting  = (state == addressLoad) || (state == readOut) || (state == writeIn);
    assign cmdDone   = cond.sclkRise && (bitCount == countWidth'(cmdBits - 1));
    assign dataDone  = cond.sclkRise && (bitCount == countWidth'(dataBits - 1));
    assign readFrame = mem.shiftData[rwBitIndex];   // valid in branch

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (cond.selectStart) begin
                    nextState = addressLoad;
                end
            end
            addressLoad: begin
                if (cmdDone) begin
                    nextState = branch;
                end
            end
            branch: begin
                nextState = readFrame ? dataLoad : writeIn;
            end
            dataLoad: begin
                nextState = readOut;            // one clk for the memory read
            end
            readOut, writeIn: begin
                if (dataDone) begin
                    nextState = done;
                end
            end
            done: begin
                nextState = done;
            end
            default: begin
                nextState = idle;
            end
        endcase
        // Deselect wins in every state. A pending write is dropped.
        if (!cond.selected) begin
            nextState = idle;
        end
    end

    // ------------------------------
    // state, counter, controls
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= idle;
            bitCount        <= '0;
            shiftLoad       <= 1'b0;
            misoEnable      <= 1'b0;
            mem.writeEnable <= 1'b0;
        end else begin
            state <= nextState;

            if (nextState != state) begin
                bitCount <= '0;                 // fresh count for every phase
            end else if (cond.sclkRise && counting) begin
                bitCount <= bitCount + 1'b1;
            end

            // readData is valid the cycle after dataLoad
            shiftLoad <= (state == dataLoad) && cond.selected;

            // byte is complete in the shifter once the last rise is taken
            mem.writeEnable <= (state == writeIn) && dataDone && cond.selected;

            if (nextState == idle) begin
                misoEnable <= 1'b0;
            end else if (nextState == dataLoad) begin
                misoEnable <= 1'b1;
            end
        end
    end

    assign mem.addrLoad = (state == branch);

endmodule

//--- inputConditioner.sv
module inputConditioner (
    input  logic   clk,
    input  logic   reset,
    input  logic   sclk,
    input  logic   mosi,
    input  logic   chipSelect,
    condBus.source cond
);

    logic [1:0] sclkMeta;
    logic [1:0] mosiMeta;
    logic [1:0] csMeta;
    logic       sclkPrev;

    // ------------------------------
    // two-flop synchronizers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            sclkMeta <= '0;                     // mode 0 idles low
            mosiMeta <= '0;
            csMeta   <= '1;                     // deselected
        end else begin
            sclkMeta <= {sclkMeta[0], sclk};
            mosiMeta <= {mosiMeta[0], mosi};
            csMeta   <= {csMeta[0], chipSelect};
        end
    end

    // ------------------------------
    // edge stage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            sclkPrev         <= 1'b0;
            cond.sclkRise    <= 1'b0;
            cond.sclkFall    <= 1'b0;
            cond.mosiSync    <= 1'b0;
            cond.selected    <= 1'b0;
            cond.selectStart <= 1'b0;
        end else begin
            sclkPrev         <= sclkMeta[1];
            cond.sclkRise    <= sclkMeta[1] & ~sclkPrev;
            cond.sclkFall    <= ~sclkMeta[1] & sclkPrev;
            cond.mosiSync    <= mosiMeta[1];    // same depth as the strobes
            cond.selected    <= ~csMeta[1];
            // selected still holds the previous level here
            cond.selectStart <= ~csMeta[1] & ~cond.selected;
        end
    end

endmodule

//--- memPkg.sv
package memPkg;

    // ------------------------------
    // memory geometry
    // ------------------------------
    localparam int addrWidth = 7;
    localparam int dataWidth = 8;
    localparam int memDepth  = 1 << addrWidth;  // 128 bytes

endpackage

//--- run.sh
#!/bin/sh
# build and run the SPI memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module spiMemoryTb -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "run.sh: Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "run.sh: pass message not found in simulation output"
exit 1

//--- shiftRegister.sv
module shiftRegister import memPkg::*; (
    input  logic    clk,
    input  logic    reset,
    condBus.sink    cond,
    memPort.shifter mem,
    input  logic    shiftLoad,
    output logic    miso
);

    logic [dataWidth-1:0] shiftReg;

    // ------------------------------
    // parallel side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (cond.selectStart) begin
            shiftReg <= '0;                     // drop leftovers of the last frame
        end else if (shiftLoad) begin
            shiftReg <= mem.readData;
        end else if (cond.sclkRise && cond.selected) begin
            shiftReg <= {shiftReg[dataWidth-2:0], cond.mosiSync};
        end
    end

    assign mem.shiftData = shiftReg;

    // ------------------------------
    // serial out
    // ------------------------------
    // mode 0: change on the falling edge, master samples on the rising one
    always_ff @(posedge clk) begin
        if (reset) begin
            miso <= 1'b0;
        end else if (!cond.selected) begin
            miso <= 1'b0;                       // quiet between frames
        end else if (cond.sclkFall) begin
            miso <= shiftReg[dataWidth-1];
        end
    end

endmodule

//--- spiIfs.sv
// conditioned pin activity, all registered in the conditioner
interface condBus;
    logic sclkRise;                             // one-cycle strobes
    logic sclkFall;
    logic mosiSync;
    logic selected;                             // chip select, active high here
    logic selectStart;                          // one cycle at frame start

    modport source (
        output sclkRise,
        output sclkFall,
        output mosiSync,
        output selected,
        output selectStart
    );

    modport sink (
        input sclkRise,
        input sclkFall,
        input mosiSync,
        input selected,
        input selectStart
    );
endinterface

// memory access between controller, shifter and memory
interface memPort import memPkg::*; ();
    logic                 addrLoad;
    logic                 writeEnable;
    logic [dataWidth-1:0] shiftData;            // address byte or data byte
    logic [dataWidth-1:0] readData;

    modport controller (
        output addrLoad,
        output writeEnable,
        input  shiftData                        // r/w bit is read from here
    );

    modport shifter (
        output shiftData,
        input  readData
    );

    modport memory (
        input  addrLoad,
        input  writeEnable,
        input  shiftData,
        output readData
    );
endinterface

//--- spiMemory.sv
module spiMemory (
    input  logic clk,
    input  logic reset,
    input  logic sclk,
    input  logic mosi,
    input  logic chipSelect,
    output logic miso,
    output logic misoEnable
);

    condBus cond ();
    memPort mem ();

    logic shiftLoad;

    // ------------------------------
    // pipeline stages
    // ------------------------------
    inputConditioner conditioner (
        .clk        (clk),
        .reset      (reset),
        .sclk       (sclk),
        .mosi       (mosi),
        .chipSelect (chipSelect),
        .cond       (cond)
    );

    shiftRegister shifter (
        .clk       (clk),
        .reset     (reset),
        .cond      (cond),
        .mem       (mem),
        .shiftLoad (shiftLoad),
        .miso      (miso)
    );

    frameController controller (
        .clk        (clk),
        .reset      (reset),
        .cond       (cond),
        .mem        (mem),
        .shiftLoad  (shiftLoad),
        .misoEnable (misoEnable)
    );

    dataMemory memory (
        .clk   (clk),
        .reset (reset),
        .mem   (mem)
    );

endmodule

//--- spiMemoryTb.sv
module spiMemoryTb import spiPkg::*, memPkg::*; ();

    localparam int sclkHalf      = 8;           // clk cycles per sclk half period
    localparam int gapCycles     = 2 * sclkHalf;
    localparam int resetCycles   = 8;
    localparam int idleToggles   = 8;
    localparam int writeCount    = 20;
    localparam int pairCount     = 4;
    localparam int frameBits     = cmdBits + dataBits;
    localparam int frameCycles   = frameBits * 2 * sclkHalf + sclkHalf + gapCycles;
    localparam int totalFrames   = 2 + 2 * writeCount + 3 + 2 + 2 * pairCount;
    localparam int setupCycles   = resetCycles + idleToggles * sclkHalf;
    localparam int timeoutCycles = (totalFrames * frameCycles + setupCycles) * 3 / 2;

    logic clk;
    logic reset;
    logic sclk;
    logic mosi;
    logic chipSelect;
    logic miso;
    logic misoEnable;

    logic [31:0]          lfsrState;
    logic [dataWidth-1:0] refMem [memDepth];    // expected memory contents
    int                   cycleCount = 0;

    // misoEnable seen by the master during the last frame
    logic frameEnableAny;
    logic addrEnableAny;
    logic dataEnableAll;
    logic inAddrPhase;

    tbClock clockGen (
        .clk (clk)
    );

    spiMemory uut (
        .clk        (clk),
        .reset      (reset),
        .sclk       (sclk),
        .mosi       (mosi),
        .chipSelect (chipSelect),
        .miso       (miso),
        .misoEnable (misoEnable)
    );

    // ------------------------------
    // error handling
    // ------------------------------
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expectByte(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
        assert (actual === expected) else begin
            abortRun($sformatf("Mismatch at %0t: %s, got 8'h%h, expected 8'h%h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic expectBit(input logic actual, input logic expected, input string what);
        assert (actual === expected) else begin
            abortRun($sformatf("Mismatch at %0t: %s, got %b, expected %b",
                               $time, what, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            abortRun($sformatf("Timeout: tests still running after %0d clock cycles",
                               timeoutCycles));
        end
    end

    // ------------------------------
    // random numbers
    // ------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic feedback;
        feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], feedback};
    endfunction

    task automatic takeBits(input int count, output logic [7:0] value);
        value = '0;
        repeat (count) begin
            lfsrState = lfsrNext(lfsrState);    // one step per bit
            value     = {value[6:0], lfsrState[0]};
        end
    endtask

    // ------------------------------
    // SPI master
    // ------------------------------
    task automatic clkWait(input int count);
        repeat (count) begin
            @(negedge clk);
            frameEnableAny = frameEnableAny | misoEnable;
            if (inAddrPhase) begin
                addrEnableAny = addrEnableAny | misoEnable;
            end
        end
    endtask

    // mode 0 with MSB first and sclk idling low
    task automatic spiTransfer(input logic [15:0] txBits, input int bitsSent,
                               output logic [7:0] rxByte);
        logic [15:0] txShift;
        logic [7:0]  rx;
        int          i;
        txShift        = txBits;
        rx             = '0;
        frameEnableAny = 1'b0;
        addrEnableAny  = 1'b0;
        dataEnableAll  = 1'b1;
        inAddrPhase    = 1'b1;
        chipSelect     = 1'b0;
        mosi           = txShift[15];
        for (i = 0; i < bitsSent; i++) begin
            clkWait(sclkHalf);
            if (i >= cmdBits) begin
                rx            = {rx[6:0], miso};    // sampled just before the rise
                dataEnableAll = dataEnableAll & misoEnable;
            end
            sclk = 1'b1;
            if (i == cmdBits - 1) begin
                inAddrPhase = 1'b0;
            end
            clkWait(sclkHalf);
            sclk    = 1'b0;
            txShift = {txShift[14:0], 1'b0};
            mosi    = txShift[15];
        end
        clkWait(sclkHalf);
        chipSelect = 1'b1;
        mosi       = 1'b0;
        clkWait(gapCycles);
        rxByte = rx;
    endtask

    task automatic spiWrite(input logic [addrWidth-1:0] address, input logic [7:0] data);
        logic [7:0] rx;
        spiTransfer({address, 1'b0, data}, frameBits, rx);
        refMem[address] = data;
    endtask

    task automatic spiRead(input logic [addrWidth-1:0] address, output logic [7:0] data);
        spiTransfer({address, 1'b1, 8'h00}, frameBits, data);
    endtask

    // chip select rises after bitsSent data bits and memory stays unchanged
    task automatic spiAbort(input logic [addrWidth-1:0] address, input logic [7:0] data,
                            input int bitsSent);
        logic [7:0] rx;
        spiTransfer({address, 1'b0, data}, cmdBits + bitsSent, rx);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic idleOutputs();
        logic [7:0] bits;
        expectBit(misoEnable, 1'b0, "misoEnable after reset");
        expectBit(miso, 1'b0, "miso after reset");
        repeat (idleToggles) begin
            takeBits(1, bits);
            mosi = bits[0];
            sclk = ~sclk;                       // chip select stays high
            repeat (sclkHalf) begin
                @(negedge clk);
                expectBit(misoEnable, 1'b0, "misoEnable while deselected");
                expectBit(miso, 1'b0, "miso while deselected");
            end
        end
    endtask

    task automatic writeThenRead();
        logic [7:0] got;
        spiWrite(7'h2a, 8'hc5);
        spiRead(7'h2a, got);
        expectByte(got, 8'hc5, "read back of address 2a");
    endtask

    task automatic independentAddresses();
        logic [7:0]           value;
        logic [7:0]           data;
        logic [7:0]           got;
        logic [addrWidth-1:0] addr;
        logic [addrWidth-1:0] addrList [$];
        logic                 seen [memDepth];
        int                   n;
        foreach (seen[a]) begin
            seen[a] = 1'b0;
        end
        for (n = 0; n < writeCount; n++) begin
            if (n == writeCount - 1) begin
                addr = addrList[0];             // land on an earlier address again
                data = ~refMem[addr];
            end else begin
                takeBits(addrWidth, value);
                addr = value[addrWidth-1:0];
                takeBits(dataWidth, data);
            end
            spiWrite(addr, data);               // repeats overwrite in refMem too
            if (!seen[addr]) begin
                seen[addr] = 1'b1;
                addrList.push_back(addr);
            end
        end
        foreach (addrList[k]) begin
            spiRead(addrList[k], got);
            expectByte(got, refMem[addrList[k]],
                       $sformatf("read of address %h", addrList[k]));
        end
    endtask

    task automatic abortedWrite();
        logic [7:0]           value;
        logic [7:0]           oldData;
        logic [7:0]           got;
        logic [addrWidth-1:0] addr;
        takeBits(addrWidth, value);
        addr = value[addrWidth-1:0];
        takeBits(dataWidth, oldData);
        spiWrite(addr, oldData);
        spiAbort(addr, ~oldData, 4);
        spiRead(addr, got);
        expectByte(got, oldData, "read after aborted write");
    endtask

    task automatic outputEnablePhases();
        logic [7:0]           value;
        logic [7:0]           data;
        logic [7:0]           got;
        logic [addrWidth-1:0] addr;
        takeBits(addrWidth, value);
        addr = value[addrWidth-1:0];
        takeBits(dataWidth, data);
        spiWrite(addr, data);
        expectBit(frameEnableAny, 1'b0, "misoEnable during write frame");
        spiRead(addr, got);
        expectBit(addrEnableAny, 1'b0, "misoEnable during address phase of read");
        expectBit(dataEnableAll, 1'b1, "misoEnable during data bits of read");
        expectBit(misoEnable, 1'b0, "misoEnable after chip select rose");
        expectByte(got, data, "read data in output enable test");
    endtask

    task automatic backToBackFrames();
        logic [7:0]           value;
        logic [7:0]           data;
        logic [7:0]           got;
        logic [addrWidth-1:0] addr;
        logic [addrWidth-1:0] addrQueue [$];
        repeat (pairCount) begin
            takeBits(addrWidth, value);
            addr = value[addrWidth-1:0];
            takeBits(dataWidth, data);
            spiWrite(addr, data);
            addrQueue.push_back(addr);
        end
        foreach (addrQueue[k]) begin
            spiRead(addrQueue[k], got);
            expectByte(got, refMem[addrQueue[k]],
                       $sformatf("back-to-back read of address %h", addrQueue[k]));
        end
    endtask

    // ------------------------------
    // sequence
    // ------------------------------
    initial begin
        reset          = 1'b1;
        sclk           = 1'b0;
        mosi           = 1'b0;
        chipSelect     = 1'b1;
        lfsrState      = 32'h20ae_568b;
        frameEnableAny = 1'b0;
        addrEnableAny  = 1'b0;
        dataEnableAll  = 1'b1;
        inAddrPhase    = 1'b0;
        repeat (resetCycles) begin
            @(negedge clk);
        end
        reset = 1'b0;

        idleOutputs();
        writeThenRead();
        independentAddresses();
        abortedWrite();
        outputEnablePhases();
        backToBackFrames();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- spiPkg.sv
package spiPkg;

    // ------------------------------
    // frame layout
    // ------------------------------
    localparam int cmdBits  = 8;                // 7 address bits + r/w bit
    localparam int dataBits = 8;

    // position of the r/w flag inside the command byte, 1 = read
    localparam int rwBitIndex = 0;

    // wide enough for the longer of the two phases
    localparam int countWidth = $clog2((cmdBits > dataBits) ? cmdBits : dataBits);

    // ------------------------------
    // frame controller states
    // ------------------------------
    typedef enum logic [2:0] {
        idle,                                   // waiting for chip select
        addressLoad,                            // shifting in the command byte
        branch,                                 // address latched, r/w decided
        dataLoad,                               // memory read in flight
        readOut,                                // shifting the byte out on miso
        writeIn,                                // shifting the byte in from mosi
        done                                    // hold until deselected
    } frameState;

endpackage

//--- tbClock.sv
module tbClock (
    output logic clk
);

    localparam int halfPeriod = 50;             // full period of 100

    initial begin
        clk = 1'b0;
    end

    always begin
        #halfPeriod clk = ~clk;
    end

endmodule
